//--- mem_pkg.sv
// Shared memory types for the game ROM bank
// Bus widths, operation and request-origin enums
// Request and response structs
package mem_pkg;

    localparam int MEM_AW = 22;  // Word address
    localparam int MEM_DW = 16;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    // Request origin, also the read data tag
    typedef enum logic [1:0] {
        SLOT_DWNLD,
        SLOT_MAIN,
        SLOT_CHAR
    } slot_e;

    typedef struct packed {
        mem_op_e           op;
        slot_e             tag;
        logic [MEM_AW-1:0] addr;
        logic [MEM_DW-1:0] data;
        logic [1:0]        sel;   // Active high, bit 1 is the upper byte
    } mem_req_t;

    typedef struct packed {
        slot_e             tag;
        logic [MEM_DW-1:0] data;
    } mem_rsp_t;

endpackage

//--- rom_dwnld.sv
// ROM download unpacker
// Skips the file header and latches the game id from it
// Turns each image byte into a masked word write
`timescale 1ns/10ps

module rom_dwnld #(
    parameter int HEADER = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              downloading,
    input  logic [24:0]       ioctl_addr,
    input  logic [7:0]        ioctl_dout,
    input  logic              ioctl_wr,
    output mem_pkg::mem_req_t prog_req,
    output logic              prog_valid,
    input  logic              prog_ack,
    output logic [7:0]        game_id,
    output logic              dwnld_busy
);

    localparam logic [24:0] HDR_LEN     = 25'(HEADER);
    localparam logic [24:0] GAME_ID_POS = 25'h18;

    logic [24:0] rom_offset;  // Byte offset inside the image
    logic        in_header;
    logic        img_wr;

    assign rom_offset = ioctl_addr - HDR_LEN;
    assign in_header  = ioctl_addr < HDR_LEN;
    assign img_wr     = downloading && ioctl_wr && !in_header;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_valid <= 1'b0;
            game_id    <= 8'h00;
        end else begin
            if (prog_ack)
                prog_valid <= 1'b0;
            if (img_wr)
                prog_valid <= 1'b1;  // Held until the arbiter takes it
            if (downloading && ioctl_wr && in_header && ioctl_addr == GAME_ID_POS)
                game_id <= ioctl_dout;
        end
    end

    // Even bytes land in the upper half, so words come out big-endian
    always_ff @(posedge clk) begin
        if (img_wr) begin
            prog_req.op   <= mem_pkg::OP_WRITE;
            prog_req.tag  <= mem_pkg::SLOT_DWNLD;
            prog_req.addr <= rom_offset[mem_pkg::MEM_AW:1];
            prog_req.data <= {ioctl_dout, ioctl_dout};
            prog_req.sel  <= rom_offset[0] ? 2'b01 : 2'b10;
        end
    end

    assign dwnld_busy = downloading | prog_valid;

endmodule

//--- slot_arbiter.sv
// Memory access arbiter
// Download writes first, then main CPU reads, then char reads
// Keeps address, data and state of each read slot
`timescale 1ns/10ps

module slot_arbiter #(
    parameter logic [21:0] CHAR_OFFSET = 22'h08_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              downloading,
    input  mem_pkg::mem_req_t prog_req,
    input  logic              prog_valid,
    output logic              prog_ack,
    input  logic              main_cs,
    input  logic [17:0]       main_addr,
    output logic [15:0]       main_data,
    output logic              main_ok,
    input  logic              char_cs,
    input  logic [12:0]       char_addr,
    output logic [15:0]       char_data,
    output logic              char_ok,
    output logic              push,
    output mem_pkg::mem_req_t push_req,
    input  logic              full,
    input  mem_pkg::mem_rsp_t rsp,
    input  logic              rsp_valid
);

    typedef enum logic [1:0] {
        SLOT_IDLE,   // No valid data
        SLOT_WAIT,   // Read in flight
        SLOT_READY
    } slot_st_e;

    localparam int NSLOT = 2;  // 0 is main, 1 is char

    slot_st_e                      st        [NSLOT];
    logic [mem_pkg::MEM_AW-1:0]    last_addr [NSLOT];
    logic [mem_pkg::MEM_DW-1:0]    data      [NSLOT];
    logic [mem_pkg::MEM_AW-1:0]    cur_addr  [NSLOT];
    logic [NSLOT-1:0]              cs;
    logic [NSLOT-1:0]              want;
    logic [NSLOT-1:0]              grant;
    logic [NSLOT-1:0]              rsp_hit;
    logic [NSLOT-1:0]              ok;

    function automatic mem_pkg::slot_e slot_tag(input int idx);
        return (idx == 0) ? mem_pkg::SLOT_MAIN : mem_pkg::SLOT_CHAR;
    endfunction

    assign cs[0]       = main_cs;
    assign cs[1]       = char_cs;
    assign cur_addr[0] = {4'd0, main_addr};
    assign cur_addr[1] = CHAR_OFFSET + {9'd0, char_addr};

    always_comb begin
        for (int i = 0; i < NSLOT; i++) begin
            // New address or no data yet, one read at a time
            want[i] = cs[i] && !downloading && st[i] != SLOT_WAIT &&
                      (st[i] == SLOT_IDLE || cur_addr[i] != last_addr[i]);
            rsp_hit[i] = rsp_valid && rsp.tag == slot_tag(i);
            ok[i]      = st[i] == SLOT_READY && cs[i] && cur_addr[i] == last_addr[i];
        end
    end

    // Fixed priority
    assign prog_ack = prog_valid && !full;
    assign grant[0] = want[0] && !full && !prog_valid;
    assign grant[1] = want[1] && !full && !prog_valid && !want[0];
    assign push     = prog_ack || (|grant);

    always_comb begin
        push_req = prog_req;
        if (!prog_valid) begin
            push_req.op   = mem_pkg::OP_READ;
            push_req.tag  = grant[1] ? mem_pkg::SLOT_CHAR : mem_pkg::SLOT_MAIN;
            push_req.addr = grant[1] ? cur_addr[1] : cur_addr[0];
            push_req.data = '0;
            push_req.sel  = 2'b11;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NSLOT; i++)
                st[i] <= SLOT_IDLE;
        end else begin
            for (int i = 0; i < NSLOT; i++) begin
                if (grant[i]) begin
                    st[i] <= SLOT_WAIT;
                end else if (rsp_hit[i]) begin
                    // Stale data is dropped, the slot asks again
                    st[i] <= (cur_addr[i] == last_addr[i]) ? SLOT_READY : SLOT_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NSLOT; i++) begin
            if (grant[i])
                last_addr[i] <= cur_addr[i];
            if (rsp_hit[i])
                data[i] <= rsp.data;
        end
    end

    assign main_data = data[0];
    assign main_ok   = ok[0];
    assign char_data = data[1];
    assign char_ok   = ok[1];

endmodule

//--- req_queue.sv
// Request FIFO between the arbiter and the bus master
// Circular buffer with read and write pointers and a count
`timescale 1ns/10ps

module req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  mem_pkg::mem_req_t push_req,
    output logic              full,
    input  logic              pop,
    output mem_pkg::mem_req_t pop_req,
    output logic              empty
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    mem_pkg::mem_req_t mem [QUEUE_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              do_push;
    logic              do_pop;

    assign full    = count == CW'(QUEUE_DEPTH);
    assign empty   = count == '0;
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign pop_req = mem[rd_ptr];

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_req;
    end

endmodule

//--- wb_mem_master.sv
// Wishbone classic master
// One bus cycle per queued request, read data returned with its tag
`timescale 1ns/10ps

module wb_mem_master (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t pop_req,
    input  logic              empty,
    output logic              pop,
    output mem_pkg::mem_rsp_t rsp,
    output logic              rsp_valid,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [21:0]       wb_adr,
    output logic [15:0]       wb_dat_o,
    output logic [1:0]        wb_sel,
    input  logic [15:0]       wb_dat_i,
    input  logic              wb_ack
);

    typedef enum logic {
        BUS_IDLE,
        BUS_CYCLE
    } bus_st_e;

    bus_st_e           state;
    mem_pkg::mem_req_t cur;  // Request on the bus

    assign pop = state == BUS_IDLE && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= BUS_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (pop)
                        state <= BUS_CYCLE;
                end
                BUS_CYCLE: begin
                    if (wb_ack) begin
                        state     <= BUS_IDLE;  // cyc and stb drop next cycle
                        rsp_valid <= cur.op == mem_pkg::OP_READ;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            cur <= pop_req;
        if (state == BUS_CYCLE && wb_ack) begin
            rsp.tag  <= cur.tag;
            rsp.data <= wb_dat_i;
        end
    end

    // Outputs held stable for the whole cycle
    assign wb_cyc   = state == BUS_CYCLE;
    assign wb_stb   = state == BUS_CYCLE;
    assign wb_we    = cur.op == mem_pkg::OP_WRITE;
    assign wb_adr   = cur.addr;
    assign wb_dat_o = cur.data;
    assign wb_sel   = cur.sel;

endmodule

//--- game_sdram.sv
// Game ROM memory mapping, top level
// Download unpacker, slot arbiter, request FIFO and Wishbone master
`timescale 1ns/10ps

module game_sdram #(
    parameter int          HEADER      = 32,
    parameter logic [21:0] CHAR_OFFSET = 22'h08_0000,
    parameter int          QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    // ROM download
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output logic [7:0]  game_id,
    output logic        dwnld_busy,
    // Main CPU ROM
    input  logic        main_cs,
    input  logic [17:0] main_addr,
    output logic [15:0] main_data,
    output logic        main_ok,
    // Char tiles
    input  logic        char_cs,
    input  logic [12:0] char_addr,
    output logic [15:0] char_data,
    output logic        char_ok,
    // Wishbone to external memory
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [21:0] wb_adr,
    output logic [15:0] wb_dat_o,
    output logic [1:0]  wb_sel,
    input  logic [15:0] wb_dat_i,
    input  logic        wb_ack
);

    mem_pkg::mem_req_t prog_req;
    mem_pkg::mem_req_t push_req;
    mem_pkg::mem_req_t pop_req;
    mem_pkg::mem_rsp_t rsp;
    logic              prog_valid;
    logic              prog_ack;
    logic              push;
    logic              full;
    logic              pop;
    logic              empty;
    logic              rsp_valid;

    rom_dwnld #(
        .HEADER      (HEADER)
    ) rom_dwnld_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog_req    (prog_req),
        .prog_valid  (prog_valid),
        .prog_ack    (prog_ack),
        .game_id     (game_id),
        .dwnld_busy  (dwnld_busy)
    );

    slot_arbiter #(
        .CHAR_OFFSET (CHAR_OFFSET)
    ) slot_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .prog_req    (prog_req),
        .prog_valid  (prog_valid),
        .prog_ack    (prog_ack),
        .main_cs     (main_cs),
        .main_addr   (main_addr),
        .main_data   (main_data),
        .main_ok     (main_ok),
        .char_cs     (char_cs),
        .char_addr   (char_addr),
        .char_data   (char_data),
        .char_ok     (char_ok),
        .push        (push),
        .push_req    (push_req),
        .full        (full),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid)
    );

    req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) req_queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_req    (push_req),
        .full        (full),
        .pop         (pop),
        .pop_req     (pop_req),
        .empty       (empty)
    );

    wb_mem_master wb_mem_master_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pop_req     (pop_req),
        .empty       (empty),
        .pop         (pop),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_sel      (wb_sel),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack)
    );

endmodule

//--- tb_wb_mem.sv
// Wishbone classic slave memory model for the testbench
// Two 64-word windows, at word 0 and at the char offset
// LFSR-driven wait states of 0 to 3 cycles per transfer
`timescale 1ns/10ps

module tb_wb_mem #(
    parameter logic [21:0] CHAR_OFFSET = 22'h08_0000,
    parameter logic [31:0] SEED        = 32'h4b4e22c7
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [21:0] adr,
    input  logic [15:0] dat_w,
    input  logic [1:0]  sel,
    output logic [15:0] dat_r,
    output logic        ack
);

    logic [15:0] mem [128];
    logic [31:0] lfsr;
    logic [1:0]  delay;  // Wait states left in this transfer
    logic [6:0]  idx;

    // Upper index bit picks the window
    assign idx = {adr >= CHAR_OFFSET, adr[5:0]};

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic step_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [1:0] rand_wait();
        logic [1:0] w;
        w[1] = step_bit();
        w[0] = step_bit();
        return w;
    endfunction

    initial begin
        lfsr  = SEED;
        ack   = 1'b0;
        dat_r = '0;
        delay = 2'd0;
        for (int i = 0; i < 128; i++)
            mem[i] = 16'hc3a5 ^ 16'(i * 257);  // Fill pattern over the whole index
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            delay <= 2'd0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (delay == 2'd0) begin
                    ack   <= 1'b1;
                    delay <= rand_wait();  // For the next transfer
                    if (we && sel[1])
                        mem[idx][15:8] <= dat_w[15:8];
                    if (we && sel[0])
                        mem[idx][7:0] <= dat_w[7:0];
                    dat_r <= mem[idx];
                end else begin
                    delay <= delay - 2'd1;
                end
            end
        end
    end

endmodule

//--- tb_game_sdram.sv
// Testbench for the game ROM memory mapping block
// Downloads a random image, then reads it back through the main and char slots
// Byte-level reference of the image and concurrent checks on the outputs
`timescale 1ns/10ps

module tb_game_sdram;

    localparam int          HEADER      = 32;
    localparam logic [21:0] CHAR_OFFSET = 22'h08_0000;
    localparam logic [31:0] SEED        = 32'h4b4e22c7;
    localparam int          TIMEOUT     = 200;  // Cycles per wait

    logic        clk, rst_n, downloading, ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout, game_id;
    logic        dwnld_busy, main_cs, main_ok, char_cs, char_ok;
    logic [17:0] main_addr;
    logic [12:0] char_addr;
    logic [15:0] main_data, char_data;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [21:0] wb_adr;
    logic [15:0] wb_dat_o, wb_dat_i;
    logic [1:0]  wb_sel;
    logic [7:0]  hdr [HEADER];
    logic [7:0]  image [64];  // 32 bytes for word 0 and 32 for the char offset
    logic [31:0] lfsr;
    logic        dl_done;

    game_sdram #(
        .HEADER(HEADER), .CHAR_OFFSET(CHAR_OFFSET), .QUEUE_DEPTH(4)
    ) game_sdram_i (
        .clk(clk), .rst_n(rst_n), .downloading(downloading), .ioctl_addr(ioctl_addr),
        .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr), .game_id(game_id),
        .dwnld_busy(dwnld_busy), .main_cs(main_cs), .main_addr(main_addr),
        .main_data(main_data), .main_ok(main_ok), .char_cs(char_cs),
        .char_addr(char_addr), .char_data(char_data), .char_ok(char_ok),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    tb_wb_mem #(.CHAR_OFFSET(CHAR_OFFSET), .SEED(SEED)) mem_model_i (
        .clk(clk), .rst_n(rst_n), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_w(wb_dat_o), .sel(wb_sel), .dat_r(wb_dat_i), .ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Even image byte in the upper half and odd byte in the lower
    function automatic logic [15:0] exp_word(input logic [21:0] waddr);
        int base;
        int w;
        base = (waddr >= CHAR_OFFSET) ? 32 : 0;
        w    = int'(waddr - ((waddr >= CHAR_OFFSET) ? CHAR_OFFSET : 22'd0));
        return {image[base + 2 * w], image[base + 2 * w + 1]};
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> !wb_cyc && !wb_stb && !main_ok && !char_ok)
        else stop_run($sformatf(
            "FAILED t=%0t wb_cyc wb_stb main_ok char_ok got %b%b%b%b expected 0000",
            $time, $sampled(wb_cyc), $sampled(wb_stb), $sampled(main_ok),
            $sampled(char_ok)));
    stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else stop_run($sformatf("wb_stb high without wb_cyc at %0t", $time));
    no_read_in_dl: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && downloading |-> wb_we)
        else stop_run($sformatf("Read cycle on the bus during download at %0t", $time));
    id_match: assert property (@(posedge clk) disable iff (!rst_n) dl_done |-> game_id == hdr[24])
        else stop_run($sformatf("FAILED t=%0t game_id got %h expected %h",
                                $time, $sampled(game_id), hdr[24]));
    busy_low: assert property (@(posedge clk) disable iff (!rst_n) dl_done |-> !dwnld_busy)
        else stop_run($sformatf("FAILED t=%0t dwnld_busy got 1 expected 0", $time));
    main_match: assert property (@(posedge clk) disable iff (!rst_n)
        main_ok |-> main_data == exp_word({4'd0, main_addr}))
        else stop_run($sformatf("FAILED t=%0t main_data got %h expected %h", $time,
                                $sampled(main_data), exp_word({4'd0, $sampled(main_addr)})));
    char_match: assert property (@(posedge clk) disable iff (!rst_n)
        char_ok |-> char_data == exp_word(CHAR_OFFSET + 22'(char_addr)))
        else stop_run($sformatf("FAILED t=%0t char_data got %h expected %h", $time,
                       $sampled(char_data), exp_word(CHAR_OFFSET + 22'($sampled(char_addr)))));

    // downloading drops between bytes so dwnld_busy shows when the write is taken
    task automatic write_byte(input logic [24:0] addr, input logic [7:0] data);
        int n;
        downloading = 1'b1;
        main_cs     = 1'b1;  // Both slots ask while the download runs
        char_cs     = 1'b1;
        ioctl_addr  = addr;
        ioctl_dout  = data;
        ioctl_wr    = 1'b1;
        @(negedge clk);
        ioctl_wr    = 1'b0;
        repeat (4) @(negedge clk);  // Lets the write reach the bus with downloading high
        downloading = 1'b0;
        main_cs     = 1'b0;
        char_cs     = 1'b0;
        n = 0;
        while (dwnld_busy) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT)
                stop_run("Timeout waiting for the download write to be taken");
        end
    endtask

    task automatic wait_main_ok();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT)
                stop_run("Timeout waiting for main_ok");
        end while (!main_ok);
    endtask

    task automatic wait_char_ok();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT)
                stop_run("Timeout waiting for char_ok");
        end while (!char_ok);
    endtask

    initial begin
        lfsr = SEED;
        {rst_n, downloading, ioctl_wr, ioctl_addr, ioctl_dout, dl_done} = '0;
        {main_cs, main_addr, char_cs, char_addr} = '0;
        for (int i = 0; i < HEADER; i++)
            hdr[i] = 8'(rand_bits(8));
        for (int i = 0; i < 64; i++)
            image[i] = 8'(rand_bits(8));
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < HEADER; i++)
            write_byte(25'(i), hdr[i]);
        for (int i = 0; i < 64; i++)  // Second half lands at the char offset
            write_byte(25'(HEADER) + ((i < 32) ? 25'(i) : 25'(2 * CHAR_OFFSET) + 25'(i - 32)),
                       image[i]);
        dl_done = 1'b1;
        for (int k = 0; k < 6; k++) begin  // Main slot alone
            main_addr = 18'(rand_bits(4));
            main_cs   = 1'b1;
            wait_main_ok();
        end
        main_cs = 1'b0;
        for (int k = 0; k < 6; k++) begin  // Char slot alone
            char_addr = 13'(rand_bits(4));
            char_cs   = 1'b1;
            wait_char_ok();
        end
        for (int k = 0; k < 8; k++) begin  // Both slots together
            main_addr = 18'(rand_bits(4));
            char_addr = 13'(rand_bits(4));
            main_cs   = 1'b1;
            char_cs   = 1'b1;
            if (k % 2 == 1) begin
                @(negedge clk);
                main_addr = (main_addr + 18'd1) & 18'hf;  // Move while the read is in flight
            end
            wait_main_ok();
            wait_char_ok();
        end
        main_cs = 1'b0;
        char_cs = 1'b0;
        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- files.f
mem_pkg.sv
rom_dwnld.sv
slot_arbiter.sv
req_queue.sv
wb_mem_master.sv
game_sdram.sv
tb_wb_mem.sv
tb_game_sdram.sv
